//--- Makefile
TOP = tb_csr_file

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- rtl/csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl import csr_pkg::*; #(
    parameter int N_SAVE = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  csr_req_t                    req,
    output csr_wr_t                     wr,
    input  logic [CSR_W-1:0]            crmd_word,
    input  logic [CSR_W-1:0]            prmd_word,
    input  logic [CSR_W-1:0]            ecfg_word,
    input  logic [CSR_W-1:0]            estat_word,
    input  logic [CSR_W-1:0]            era_word,
    input  logic [CSR_W-1:0]            eentry_word,
    input  logic [CSR_W-1:0]            badv_word,
    input  logic [CSR_W-1:0]            tid_word,
    input  logic [CSR_W-1:0]            tcfg_word,
    input  logic [CSR_W-1:0]            tval_word,
    input  logic [N_SAVE-1:0][CSR_W-1:0] save_words,
    output logic [CSR_W-1:0]            rvalue
);

    always_comb begin
        wr        = '0;
        wr.wmask  = req.wmask;
        wr.wvalue = req.wvalue;
        rvalue    = '0;

        case (req.num)
            CSR_CRMD: begin
                wr.crmd = req.we;
                rvalue  = crmd_word;
            end
            CSR_PRMD: begin
                wr.prmd = req.we;
                rvalue  = prmd_word;
            end
            CSR_ECFG: begin
                wr.ecfg = req.we;
                rvalue  = ecfg_word;
            end
            CSR_ESTAT: begin
                wr.estat = req.we;
                rvalue   = estat_word;
            end
            CSR_ERA: begin
                wr.era = req.we;
                rvalue = era_word;
            end
            CSR_EENTRY: begin
                wr.eentry = req.we;
                rvalue    = eentry_word;
            end
            CSR_TID: begin
                wr.tid = req.we;
                rvalue = tid_word;
            end
            CSR_TCFG: begin
                wr.tcfg = req.we;
                rvalue  = tcfg_word;
            end
            // BADV and TVAL are read only
            CSR_BADV: rvalue = badv_word;
            CSR_TVAL: rvalue = tval_word;
            // Clear-only register, always reads zero
            CSR_TICLR: wr.ticlr = req.we;
            default: begin
                // SAVE window starting at SAVE0
                for (int i = 0; i < N_SAVE; i++) begin
                    if (req.num == CSR_NUM_W'(CSR_SAVE0 + i)) begin
                        wr.save[i] = req.we;
                        rvalue     = save_words[i];
                    end
                end
            end
        endcase
    end

    a_wr_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({wr.crmd, wr.prmd, wr.ecfg, wr.estat, wr.era, wr.eentry,
                  wr.tid, wr.tcfg, wr.ticlr, wr.save}));

endmodule

//--- rtl/csr_except_regs.sv
`timescale 1ns/1ps

module csr_except_regs import csr_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  csr_wr_t          wr,
    input  exc_evt_t         evt,
    input  logic [7:0]       hw_int,
    input  logic             ipi,
    input  logic             timer_fire,
    input  logic             crmd_ie,
    output logic             has_int,
    output logic [CSR_W-1:0] estat_word,
    output logic [CSR_W-1:0] ecfg_word,
    output logic [CSR_W-1:0] badv_word
);

    logic [IS_W-1:0]  estat_is;
    logic [5:0]       estat_ecode;
    logic [8:0]       estat_esubcode;
    logic [IS_W-1:0]  ecfg_lie;
    logic [CSR_W-1:0] badv;

    logic [CSR_W-1:0] estat_wr;
    logic [CSR_W-1:0] ecfg_wr;
    logic             ticlr_clr;
    logic             addr_err;

    assign estat_wr  = csr_merge(estat_word, wr.wvalue, wr.wmask);
    assign ecfg_wr   = csr_merge(ecfg_word, wr.wvalue, wr.wmask);
    assign ticlr_clr = wr.ticlr && wr.wmask[0] && wr.wvalue[0];
    assign addr_err  = (evt.ecode == ECODE_ADE) || (evt.ecode == ECODE_ALE);

    // Hardware and IPI bits are resampled every cycle, reset included
    always_ff @(posedge clk) begin
        estat_is[9:2] <= hw_int;
        estat_is[10]  <= 1'b0;
        estat_is[12]  <= ipi;
        if (reset) begin
            estat_is[1:0]        <= 2'b00;
            estat_is[IS_TIMER_BIT] <= 1'b0;
        end else begin
            if (wr.estat) begin
                estat_is[1:0] <= estat_wr[1:0];
            end
            // A firing timer wins over a clear in the same cycle
            if (timer_fire) begin
                estat_is[IS_TIMER_BIT] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[IS_TIMER_BIT] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (evt.ex) begin
            estat_ecode    <= evt.ecode;
            estat_esubcode <= evt.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wr.ecfg) begin
            ecfg_lie <= ecfg_wr[IS_W-1:0] & LIE_MASK;
        end
    end

    // Fetch faults report the PC, data faults the address
    always_ff @(posedge clk) begin
        if (evt.ex && addr_err) begin
            if (evt.ecode == ECODE_ADE && evt.esubcode == ESUBCODE_ADEF) begin
                badv <= evt.pc;
            end else begin
                badv <= evt.vaddr;
            end
        end
    end

    assign has_int    = (|(estat_is & ecfg_lie)) && crmd_ie;
    assign estat_word = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign ecfg_word  = {{(CSR_W-IS_W){1'b0}}, ecfg_lie};
    assign badv_word  = badv;

    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(evt.ex && evt.ertn));

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*; #(
    parameter int N_SAVE = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  csr_req_t         req,
    input  exc_evt_t         evt,
    input  logic [7:0]       hw_int,
    input  logic             ipi,
    output logic [CSR_W-1:0] rvalue,
    output logic             has_int,
    output logic [CSR_W-1:0] eentry,
    output logic [CSR_W-1:0] era
);

    csr_wr_t                      wr;
    logic                         crmd_ie;
    logic                         timer_fire;
    logic [CSR_W-1:0]             crmd_word;
    logic [CSR_W-1:0]             prmd_word;
    logic [CSR_W-1:0]             estat_word;
    logic [CSR_W-1:0]             ecfg_word;
    logic [CSR_W-1:0]             badv_word;
    logic [CSR_W-1:0]             tcfg_word;
    logic [CSR_W-1:0]             tval_word;
    logic [CSR_W-1:0]             tid_word;
    logic [N_SAVE-1:0][CSR_W-1:0] save_words;

    csr_access_ctrl #(.N_SAVE(N_SAVE)) i_access_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .wr          (wr),
        .crmd_word   (crmd_word),
        .prmd_word   (prmd_word),
        .ecfg_word   (ecfg_word),
        .estat_word  (estat_word),
        .era_word    (era),
        .eentry_word (eentry),
        .badv_word   (badv_word),
        .tid_word    (tid_word),
        .tcfg_word   (tcfg_word),
        .tval_word   (tval_word),
        .save_words  (save_words),
        .rvalue      (rvalue)
    );

    csr_priv_regs i_priv_regs (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .evt         (evt),
        .crmd_ie     (crmd_ie),
        .crmd_word   (crmd_word),
        .prmd_word   (prmd_word),
        .era_word    (era),
        .eentry_word (eentry)
    );

    csr_except_regs i_except_regs (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .evt        (evt),
        .hw_int     (hw_int),
        .ipi        (ipi),
        .timer_fire (timer_fire),
        .crmd_ie    (crmd_ie),
        .has_int    (has_int),
        .estat_word (estat_word),
        .ecfg_word  (ecfg_word),
        .badv_word  (badv_word)
    );

    csr_timer i_timer (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .timer_fire (timer_fire),
        .tcfg_word  (tcfg_word),
        .tval_word  (tval_word)
    );

    csr_scratch_regs #(.N_SAVE(N_SAVE)) i_scratch_regs (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .save_words (save_words),
        .tid_word   (tid_word)
    );

endmodule

//--- rtl/csr_pkg.sv
package csr_pkg;

    localparam int CSR_W        = 32;
    localparam int CSR_NUM_W    = 14;
    localparam int IS_W         = 13;
    localparam int IS_TIMER_BIT = 11;

    // Architectural limit on SAVE registers
    localparam int SAVE_MAX = 16;

    // Bit 10 of LIE is reserved
    localparam logic [IS_W-1:0] LIE_MASK = 13'h1bff;

    // Exception codes that update BADV
    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef struct packed {
        logic                 we;
        logic [CSR_NUM_W-1:0] num;
        logic [CSR_W-1:0]     wmask;
        logic [CSR_W-1:0]     wvalue;
    } csr_req_t;

    // One-hot write strobes plus the shared write data
    typedef struct packed {
        logic                crmd;
        logic                prmd;
        logic                ecfg;
        logic                estat;
        logic                era;
        logic                eentry;
        logic                tid;
        logic                tcfg;
        logic                ticlr;
        logic [SAVE_MAX-1:0] save;
        logic [CSR_W-1:0]    wmask;
        logic [CSR_W-1:0]    wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic             ex;
        logic             ertn;
        logic [CSR_W-1:0] pc;
        logic [CSR_W-1:0] vaddr;
        logic [5:0]       ecode;
        logic [8:0]       esubcode;
    } exc_evt_t;

    // MSB first so the struct lines up with CRMD bits 8:0
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    function automatic logic [CSR_W-1:0] csr_merge(
        input logic [CSR_W-1:0] old_value,
        input logic [CSR_W-1:0] wvalue,
        input logic [CSR_W-1:0] wmask
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

//--- rtl/csr_priv_regs.sv
`timescale 1ns/1ps

module csr_priv_regs import csr_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  csr_wr_t          wr,
    input  exc_evt_t         evt,
    output logic             crmd_ie,
    output logic [CSR_W-1:0] crmd_word,
    output logic [CSR_W-1:0] prmd_word,
    output logic [CSR_W-1:0] era_word,
    output logic [CSR_W-1:0] eentry_word
);

    crmd_t            crmd;
    logic [1:0]       prmd_pplv;
    logic             prmd_pie;
    logic [CSR_W-1:0] era;
    logic [25:0]      eentry_va;

    logic [CSR_W-1:0] crmd_wr;
    logic [CSR_W-1:0] prmd_wr;
    logic [CSR_W-1:0] era_wr;
    logic [CSR_W-1:0] eentry_wr;

    assign crmd_wr   = csr_merge(crmd_word, wr.wvalue, wr.wmask);
    assign prmd_wr   = csr_merge(prmd_word, wr.wvalue, wr.wmask);
    assign era_wr    = csr_merge(era_word, wr.wvalue, wr.wmask);
    assign eentry_wr = csr_merge(eentry_word, wr.wvalue, wr.wmask);

    // DA set out of reset, everything else cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= crmd_t'(9'h008);
        end else if (evt.ex) begin
            crmd.plv <= 2'b00;
            crmd.ie  <= 1'b0;
        end else if (evt.ertn) begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end else if (wr.crmd) begin
            crmd <= crmd_t'(crmd_wr[$bits(crmd_t)-1:0]);
        end
    end

    // Previous mode saved on exception entry
    always_ff @(posedge clk) begin
        if (evt.ex) begin
            prmd_pplv <= crmd.plv;
            prmd_pie  <= crmd.ie;
        end else if (wr.prmd) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (evt.ex) begin
            era <= evt.pc;
        end else if (wr.era) begin
            era <= era_wr;
        end
    end

    // Entry is 64-byte aligned
    always_ff @(posedge clk) begin
        if (wr.eentry) begin
            eentry_va <= eentry_wr[CSR_W-1:6];
        end
    end

    assign crmd_ie     = crmd.ie;
    assign crmd_word   = {{(CSR_W-$bits(crmd_t)){1'b0}}, crmd};
    assign prmd_word   = {29'b0, prmd_pie, prmd_pplv};
    assign era_word    = era;
    assign eentry_word = {eentry_va, 6'b0};

endmodule

//--- rtl/csr_scratch_regs.sv
`timescale 1ns/1ps

module csr_scratch_regs import csr_pkg::*; #(
    parameter int N_SAVE = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  csr_wr_t                      wr,
    output logic [N_SAVE-1:0][CSR_W-1:0] save_words,
    output logic [CSR_W-1:0]             tid_word
);

    always_ff @(posedge clk) begin
        for (int i = 0; i < N_SAVE; i++) begin
            if (wr.save[i]) begin
                save_words[i] <= csr_merge(save_words[i], wr.wvalue, wr.wmask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_word <= '0;
        end else if (wr.tid) begin
            tid_word <= csr_merge(tid_word, wr.wvalue, wr.wmask);
        end
    end

endmodule

//--- rtl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  csr_wr_t          wr,
    output logic             timer_fire,
    output logic [CSR_W-1:0] tcfg_word,
    output logic [CSR_W-1:0] tval_word
);

    logic             tcfg_en;
    logic             tcfg_periodic;
    logic [29:0]      tcfg_initval;
    logic [CSR_W-1:0] timer_cnt;
    logic [CSR_W-1:0] tcfg_next;

    assign tcfg_next = csr_merge(tcfg_word, wr.wvalue, wr.wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr.tcfg) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[CSR_W-1:2];
        end
    end

    // All ones marks a stopped one-shot counter
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (wr.tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[CSR_W-1:2], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - CSR_W'(1);
            end
        end
    end

    assign timer_fire = tcfg_en && (timer_cnt == '0);
    assign tcfg_word  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_word  = timer_cnt;

    // Firing reloads a periodic counter or stops a one-shot one
    a_fire_reload_or_stop: assert property (@(posedge clk) disable iff (reset)
        timer_fire && !wr.tcfg |=>
            timer_cnt == (tcfg_periodic ? {tcfg_initval, 2'b00} : '1));

endmodule

//--- verification/csr_tests.svh
`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic test_reset();
    logic [31:0] v;
    read_expect("reset crmd", CSR_CRMD, 32'h0000_0008);
    read_expect("reset ecfg", CSR_ECFG, 32'h0000_0000);
    read_csr(CSR_ESTAT, v);
    check_eq("reset estat.is", 32'h0, {19'b0, v[12:0]});
    read_expect("reset tcfg", CSR_TCFG, 32'h0000_0000);
    read_expect("reset tval", CSR_TVAL, 32'hffff_ffff);
    read_expect("reset tid", CSR_TID, 32'h0000_0000);
    check_eq("reset has_int", 32'h0, {31'b0, has_int});
endtask

// Full write to get a known base, then a random masked write on top
task automatic masked_rw_one(input string name, input logic [CSR_NUM_W-1:0] num,
                             input logic [31:0] zero_bits);
    logic [31:0] base;
    logic [31:0] mask;
    logic [31:0] value;
    logic [31:0] expected;
    base  = $urandom();
    mask  = $urandom();
    value = $urandom();
    write_csr(num, 32'hffff_ffff, base);
    read_expect({name, " full"}, num, base & ~zero_bits);
    write_csr(num, mask, value);
    expected = ((mask & value) | (~mask & base)) & ~zero_bits;
    read_expect({name, " masked"}, num, expected);
endtask

task automatic test_masked_rw();
    masked_rw_one("tid", CSR_TID, 32'h0);
    masked_rw_one("eentry", CSR_EENTRY, 32'h0000_003f);
    write_csr(CSR_EENTRY, 32'hffff_ffff, 32'h1c00_0abc);
    check_eq("eentry output", 32'h1c00_0a80, eentry);
    for (int i = 0; i < N_SAVE; i++) begin
        masked_rw_one($sformatf("save%0d", i), CSR_NUM_W'(14'h030 + i), 32'h0);
    end
    read_expect("unmapped 0x100", 14'h100, 32'h0);
    read_expect("save past window", CSR_NUM_W'(14'h030 + N_SAVE), 32'h0);
endtask

task automatic test_exception();
    logic [31:0] v;
    logic [31:0] pc;
    logic [31:0] vaddr;
    pc    = $urandom();
    vaddr = $urandom();
    write_csr(CSR_CRMD, 32'h7, 32'h7);
    read_expect("crmd plv3 ie1", CSR_CRMD, 32'h0000_000f);

    raise_event(1'b1, 1'b0, pc, vaddr, ECODE_ALE, 9'h001);
    read_expect("ale crmd", CSR_CRMD, 32'h0000_0008);
    read_expect("ale prmd", CSR_PRMD, 32'h0000_0007);
    read_expect("ale era", CSR_ERA, pc);
    check_eq("ale era output", pc, era);
    read_csr(CSR_ESTAT, v);
    check_eq("ale ecode", {26'b0, ECODE_ALE}, {26'b0, v[21:16]});
    check_eq("ale esubcode", 32'h1, {23'b0, v[30:22]});
    read_expect("ale badv", CSR_BADV, vaddr);

    raise_event(1'b0, 1'b1, 32'h0, 32'h0, 6'h0, 9'h0);
    read_expect("ertn crmd", CSR_CRMD, 32'h0000_000f);

    // Fetch fault reports the PC in BADV
    pc    = $urandom();
    vaddr = $urandom();
    raise_event(1'b1, 1'b0, pc, vaddr, ECODE_ADE, ESUBCODE_ADEF);
    read_expect("adef badv", CSR_BADV, pc);
    read_expect("adef era", CSR_ERA, pc);
    read_csr(CSR_ESTAT, v);
    check_eq("adef ecode", {26'b0, ECODE_ADE}, {26'b0, v[21:16]});
endtask

task automatic test_interrupt();
    logic [31:0] v;
    write_csr(CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
    read_expect("ecfg lie", CSR_ECFG, 32'h0000_1bff);
    write_csr(CSR_CRMD, 32'h4, 32'h4);
    check_eq("no source", 32'h0, {31'b0, has_int});

    @(negedge clk);
    hw_int = 8'h08;
    #1;
    check_eq("hw_int same cycle", 32'h0, {31'b0, has_int});
    @(negedge clk);
    check_eq("hw_int has_int", 32'h1, {31'b0, has_int});
    read_csr(CSR_ESTAT, v);
    check_eq("hw_int estat.is", 32'h0000_0020, {19'b0, v[12:0]});
    write_csr(CSR_CRMD, 32'h4, 32'h0);
    check_eq("ie cleared", 32'h0, {31'b0, has_int});
    @(negedge clk);
    hw_int = 8'h00;

    write_csr(CSR_CRMD, 32'h4, 32'h4);
    check_eq("hw_int gone", 32'h0, {31'b0, has_int});
    write_csr(CSR_ESTAT, 32'h1, 32'h1);
    check_eq("swi0 has_int", 32'h1, {31'b0, has_int});
    read_csr(CSR_ESTAT, v);
    check_eq("swi0 estat.is", 32'h0000_0001, {19'b0, v[12:0]});
    write_csr(CSR_ESTAT, 32'h1, 32'h0);
    check_eq("swi0 cleared", 32'h0, {31'b0, has_int});

    write_csr(CSR_CRMD, 32'h4, 32'h0);
    write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0);
endtask

task automatic test_timer();
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] b;
    // One-shot with initval 5
    write_csr(CSR_TCFG, 32'hffff_ffff, {30'd5, 1'b0, 1'b1});
    read_expect("tcfg one-shot", CSR_TCFG, 32'h0000_0015);
    wait_timer_irq("one-shot", 40);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, v);
    check_eq("one-shot ticlr", 32'h0, {31'b0, v[IS_TIMER_BIT]});
    read_expect("one-shot stopped", CSR_TVAL, 32'hffff_ffff);

    // Periodic with initval 8
    write_csr(CSR_TCFG, 32'hffff_ffff, {30'd8, 1'b1, 1'b1});
    read_csr(CSR_TVAL, a);
    read_csr(CSR_TVAL, b);
    // Loaded with 32 and one count down by the first read
    check_eq("tval load", 32'd31, a);
    check_eq("tval step", a - 32'd1, b);
    wait_timer_irq("periodic first", 40);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, v);
    check_eq("periodic ticlr", 32'h0, {31'b0, v[IS_TIMER_BIT]});
    wait_timer_irq("periodic reload", 8 * 4 + 2);

    write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
endtask

`endif

//--- verification/tb_csr_file.sv
`timescale 1ns/1ps

module tb_csr_file import csr_pkg::*; ();

    localparam int N_SAVE = 4;

    logic             clk;
    logic             reset;
    csr_req_t         req;
    exc_evt_t         evt;
    logic [7:0]       hw_int;
    logic             ipi;
    logic [CSR_W-1:0] rvalue;
    logic             has_int;
    logic [CSR_W-1:0] eentry;
    logic [CSR_W-1:0] era;

    csr_file #(.N_SAVE(N_SAVE)) i_csr_file (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .evt     (evt),
        .hw_int  (hw_int),
        .ipi     (ipi),
        .rvalue  (rvalue),
        .has_int (has_int),
        .eentry  (eentry),
        .era     (era)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // One-cycle write with the strobe dropped on the following falling edge
    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(negedge clk);
        req.we     = 1'b1;
        req.num    = num;
        req.wmask  = mask;
        req.wvalue = value;
        @(negedge clk);
        req.we = 1'b0;
    endtask

    task automatic read_csr(input logic [CSR_NUM_W-1:0] num, output logic [31:0] value);
        @(negedge clk);
        req.we  = 1'b0;
        req.num = num;
        #1;
        value = rvalue;
    endtask

    task automatic read_expect(input string name, input logic [CSR_NUM_W-1:0] num,
                               input logic [31:0] expected);
        logic [31:0] v;
        read_csr(num, v);
        check_eq(name, expected, v);
    endtask

    task automatic raise_event(input logic ex, input logic ertn, input logic [31:0] pc,
                               input logic [31:0] vaddr, input logic [5:0] ecode,
                               input logic [8:0] esubcode);
        @(negedge clk);
        evt.ex       = ex;
        evt.ertn     = ertn;
        evt.pc       = pc;
        evt.vaddr    = vaddr;
        evt.ecode    = ecode;
        evt.esubcode = esubcode;
        @(negedge clk);
        evt = '0;
    endtask

    // Polls ESTAT until the timer bit shows up
    task automatic wait_timer_irq(input string name, input int limit);
        logic [31:0] v;
        v = '0;
        for (int n = 0; n < limit && v[IS_TIMER_BIT] !== 1'b1; n++) begin
            read_csr(CSR_ESTAT, v);
        end
        if (v[IS_TIMER_BIT] !== 1'b1) begin
            abort_run($sformatf("%s: timer interrupt not seen within %0d cycles", name, limit));
        end
    endtask

    `include "csr_tests.svh"

    initial begin
        void'($urandom(49776));
        reset  = 1'b1;
        req    = '0;
        evt    = '0;
        hw_int = 8'h00;
        ipi    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_masked_rw();
        test_exception();
        test_interrupt();
        test_timer();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
rtl/csr_pkg.sv
rtl/csr_access_ctrl.sv
rtl/csr_priv_regs.sv
rtl/csr_except_regs.sv
rtl/csr_timer.sv
rtl/csr_scratch_regs.sv
rtl/csr_file.sv
verification/tb_csr_file.sv
